// File: sources.f
rtl/cache_pkg.sv
rtl/req_gen.sv
rtl/dm_cache.sv
rtl/wb_mem.sv
rtl/cache_test_top.sv
sim/cache_test_assert.sv
sim/tb_cache_test.sv

// File: Bender.yml
package:
  name: cache_test

sources:
  - target: any(synthesis, simulation)
    files:
      - rtl/cache_pkg.sv
      - rtl/req_gen.sv
      - rtl/dm_cache.sv
      - rtl/wb_mem.sv
      - rtl/cache_test_top.sv

  - target: simulation
    files:
      - sim/cache_test_assert.sv
      - sim/tb_cache_test.sv

// File: sim/tb_cache_test.sv
/*
 * Testbench for the cache test subsystem. Two phases of random back-pressure,
 * each response checked against a generator, memory and tag model.
 */
`timescale 1ns/10ps

module tb_cache_test;

  localparam int holdoff     = 40;
  localparam int distance    = 3;
  localparam int lines       = 16;
  localparam int wait_states = 2;
  localparam int phase_len   = 300;
  localparam int cycles_per_req = 4 * (distance + wait_states + 8);  // Back-pressure margin
  localparam int watchdog_ns = 4 * 2 * ((phase_len + 1) * cycles_per_req + holdoff + 40);

  logic                  clk;
  logic                  rst;
  logic [15:0]           seed;
  logic                  rsp_ready;
  logic                  rsp_valid;
  cache_pkg::cache_rsp_t rsp;

  logic [31:0] rand_state = 32'd28466;
  logic [15:0] gen_state;
  int          gen_step;
  logic [cache_pkg::data_w-1:0] mem_model [2**cache_pkg::addr_w] = '{default: '0};
  int          tag_model   [lines];
  bit          valid_model [lines];
  int          errors = 0;
  int          checks = 0;
  int          phase_no;
  int          rsp_no;
  string       test_name;

  cache_test_top #(.holdoff(holdoff), .distance(distance), .lines(lines),
    .wait_states(wait_states)) dut0 (.clk(clk), .rst(rst), .seed(seed),
    .rsp_ready(rsp_ready), .rsp_valid(rsp_valid), .rsp(rsp));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // Random source and models
  // ==================================================
  function automatic int unsigned rand_next();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  function automatic logic [15:0] next_addr_state(input logic [15:0] x);
    logic [15:0] y;
    y = x ^ (x << 7);
    y = y ^ (y >> 9);
    y = y ^ (y << 8);
    return y;
  endfunction

  task automatic check_field(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, field,
        expected, actual);
    end
  endtask

  task automatic check_rsp(input cache_pkg::cache_rsp_t r);
    logic                         exp_we;
    logic [cache_pkg::addr_w-1:0] exp_addr;
    logic [cache_pkg::data_w-1:0] exp_data;
    logic                         exp_hit;
    int                           idx;
    int                           tag;
    if (gen_step != 2) gen_state = next_addr_state(gen_state);  // Steps 1 and 3 advance
    exp_we   = (gen_step == 1);
    exp_addr = gen_state[cache_pkg::addr_w-1:0];
    exp_data = {gen_state[14:0], gen_state[15]};
    idx      = exp_addr % lines;
    tag      = exp_addr / lines;
    exp_hit  = valid_model[idx] && (tag_model[idx] == tag);
    if (exp_we) begin
      mem_model[exp_addr] = exp_data;  // Write-through, line untouched on a miss
    end else begin
      exp_data = mem_model[exp_addr];
      if (!exp_hit) begin
        valid_model[idx] = 1'b1;  // Miss fills the line
        tag_model[idx]   = tag;
      end
    end
    gen_step  = (gen_step == 3) ? 1 : gen_step + 1;
    test_name = $sformatf("phase%0d rsp%0d", phase_no, rsp_no);
    check_field("we", exp_we, r.we);
    check_field("addr", exp_addr, r.addr);
    check_field("data", exp_data, r.data);
    check_field("hit", exp_hit, r.hit);
    rsp_no++;
  endtask

  // ==================================================
  // Phase sequencing
  // ==================================================
  task automatic run_phase(input int phase, input logic [15:0] phase_seed);
    int                    got;
    int                    since;
    logic                  v;
    cache_pkg::cache_rsp_t r;
    phase_no = phase;
    rsp_no   = 0;
    got      = 0;
    since    = 0;
    @(negedge clk);
    rst       = 1'b1;
    seed      = phase_seed;
    rsp_ready = 1'b0;
    repeat (16) @(negedge clk);
    rst       = 1'b0;
    gen_state = (phase_seed == 16'd0) ? cache_pkg::xorshift_seed_default : phase_seed;
    gen_step  = 1;
    for (int i = 0; i < lines; i++) valid_model[i] = 1'b0;  // Memory model kept
    while (got < phase_len) begin
      @(negedge clk);
      since++;
      v = rsp_valid;
      r = rsp;
      assert (!(v && since < holdoff)) else begin
        errors++;
        $display("Phase %0d: response after %0d cycles, before the holdoff", phase, since);
      end
      rsp_ready = (rand_next() % 10) < 7;
      if (v && rsp_ready) begin
        check_rsp(r);  // Transfers on the coming rising edge
        got++;
      end
    end
    // Let the next request finish its bus cycle, then hold it for reset
    do begin
      @(negedge clk);
      rsp_ready = 1'b0;
    end while (!rsp_valid);
    check_rsp(rsp);
  endtask

  initial begin
    rst       = 1'b1;
    seed      = 16'd0;
    rsp_ready = 1'b0;
    run_phase(1, 16'h3b7d);
    run_phase(2, 16'h0000);  // Zero seed takes the default
    errors += dut0.cache0.assert0.fail_cnt;
    $display("Checks: %0d, errors: %0d (protocol assertion failures: %0d)",
      checks, errors, dut0.cache0.assert0.fail_cnt);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before both phases completed", watchdog_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: sim/cache_test_assert.sv
/*
 * Protocol checks for the cache, bound into every dm_cache instance.
 */
`timescale 1ns/10ps

module cache_test_assert (
  input logic                  clk,
  input logic                  rst,
  input logic                  req_valid,
  input logic                  req_ready,
  input logic                  rsp_valid,
  input logic                  rsp_ready,
  input cache_pkg::cache_rsp_t rsp,
  input cache_pkg::wb_m2s_t    wb_m2s,
  input cache_pkg::wb_s2m_t    wb_s2m
);

  int   fail_cnt = 0;  // Read by the testbench at the end
  logic pending;       // Request accepted, response not yet taken

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (req_valid && req_ready) begin
      pending <= 1'b1;
    end else if (rsp_valid && rsp_ready) begin
      pending <= 1'b0;
    end
  end

  ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_s2m.ack |-> (wb_m2s.cyc && wb_m2s.stb) ##1 !wb_s2m.ack)
    else begin
      $error("Wishbone ack outside a strobed cycle or longer than one cycle");
      fail_cnt++;
    end

  rsp_held_stable: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
      $error("Response dropped or changed while held");
      fail_cnt++;
    end

  one_in_flight: assert property (@(posedge clk) disable iff (rst)
    pending |-> !req_ready)
    else begin
      $error("req_ready high with a response pending");
      fail_cnt++;
    end

endmodule

bind dm_cache cache_test_assert assert0 (.clk(clk), .rst(rst), .req_valid(req_valid),
  .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
  .wb_m2s(wb_m2s), .wb_s2m(wb_s2m));

// File: rtl/cache_test_top.sv
/*
 * Cache test subsystem top. Sets the parameters and connects the request
 * generator, the cache and the Wishbone memory.
 */
`timescale 1ns/10ps

module cache_test_top #(
  parameter int holdoff     = 80,  // Up to 255
  parameter int distance    = 0,   // 0 to 15
  parameter int lines       = 16,
  parameter int wait_states = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [15:0]           seed,
  input  logic                  rsp_ready,
  output logic                  rsp_valid,
  output cache_pkg::cache_rsp_t rsp
);

  logic                  req_valid;
  logic                  req_ready;
  cache_pkg::cache_req_t req;
  cache_pkg::wb_m2s_t    wb_m2s;
  cache_pkg::wb_s2m_t    wb_s2m;

  req_gen #(
    .holdoff (holdoff),
    .distance(distance)
  ) gen0 (
    .clk      (clk),
    .rst      (rst),
    .seed     (seed),
    .req_ready(req_ready),
    .req_valid(req_valid),
    .req      (req)
  );

  dm_cache #(
    .lines(lines)
  ) cache0 (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp(rsp), .rsp_ready(rsp_ready),
    .wb_m2s(wb_m2s), .wb_s2m(wb_s2m)
  );

  wb_mem #(.wait_states(wait_states)) mem0 (.clk(clk), .rst(rst), .wb_m2s(wb_m2s), .wb_s2m(wb_s2m));

endmodule

// File: rtl/wb_mem.sv
/*
 * Wishbone classic slave word memory. Answers each cycle after a
 * configurable number of wait states with a single-cycle ack.
 */
`timescale 1ns/10ps

module wb_mem #(
  parameter int wait_states = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  cache_pkg::wb_m2s_t wb_m2s,
  output cache_pkg::wb_s2m_t wb_s2m
);

  localparam int words = 2 ** cache_pkg::addr_w;
  localparam int cnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

  logic [cache_pkg::data_w-1:0] mem [words] = '{default: '0};  // Zero at power-up
  logic [cnt_w-1:0]             wait_cnt;
  logic                         ack_q;
  logic [cache_pkg::data_w-1:0] rd_data;
  logic                         active;
  logic                         done;

  assign active = wb_m2s.cyc & wb_m2s.stb & ~ack_q;
  assign done   = active && (wait_cnt == cnt_w'(wait_states));

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= done;  // One-cycle pulse
      if (done || !active) begin
        wait_cnt <= '0;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      if (wb_m2s.we) begin
        mem[wb_m2s.adr] <= wb_m2s.dat;
      end
      rd_data <= mem[wb_m2s.adr];
    end
  end

  assign wb_s2m = '{ack: ack_q, dat: rd_data};

endmodule

// File: rtl/dm_cache.sv
/*
 * Direct-mapped write-through cache with one word per line. One request is
 * in flight at a time; misses and all stores run one Wishbone classic cycle.
 */
`timescale 1ns/10ps

module dm_cache #(
  parameter int lines = 16  // Power of two
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output cache_pkg::cache_rsp_t rsp,
  input  logic                  rsp_ready,
  output cache_pkg::wb_m2s_t    wb_m2s,
  input  cache_pkg::wb_s2m_t    wb_s2m
);

  localparam int idx_w = $clog2(lines);
  localparam int tag_w = cache_pkg::addr_w - idx_w;

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_bus,
    st_respond
  } state_t;

  state_t state;

  cache_pkg::cache_req_t req_q;
  logic                  hit_q;

  logic [tag_w-1:0]             tag_arr  [lines];
  logic [cache_pkg::data_w-1:0] data_arr [lines];
  logic [lines-1:0]             valid_arr;

  logic [idx_w-1:0] idx;
  logic [tag_w-1:0] tag;
  logic             hit;
  logic             read_hit;
  logic             bus_done;

  assign idx      = req_q.addr[idx_w-1:0];
  assign tag      = req_q.addr[cache_pkg::addr_w-1:idx_w];
  assign hit      = valid_arr[idx] && (tag_arr[idx] == tag);
  assign read_hit = (state == st_lookup) && !req_q.we && hit;  // Answered at once
  assign bus_done = (state == st_bus) && wb_s2m.ack;

  // ==================================================
  // Controller
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      valid_arr <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_valid) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (read_hit) begin
            state <= rsp_ready ? st_idle : st_respond;
          end else begin
            state <= st_bus;  // Miss or store
          end
        end
        st_bus: begin
          if (wb_s2m.ack) begin
            state <= st_respond;
            if (!req_q.we) begin
              valid_arr[idx] <= 1'b1;  // Line filled
            end
          end
        end
        default: begin
          if (rsp_ready) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  assign req_ready = (state == st_idle);

  // Request capture and hit latch
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    if (state == st_lookup) begin
      hit_q <= hit;
    end
  end

  // ==================================================
  // Line arrays
  // ==================================================
  always_ff @(posedge clk) begin
    if (bus_done) begin
      if (!req_q.we) begin
        tag_arr[idx]  <= tag;
        data_arr[idx] <= wb_s2m.dat;
      end else if (hit_q) begin
        data_arr[idx] <= req_q.data;  // Store hit keeps line current
      end
    end
  end

  // Response is built from held state so it stays put under back-pressure
  assign rsp_valid = read_hit || (state == st_respond);

  always_comb begin
    rsp.we   = req_q.we;
    rsp.addr = req_q.addr;
    rsp.data = req_q.we ? req_q.data : data_arr[idx];
    rsp.hit  = (state == st_lookup) ? hit : hit_q;
  end

  // Wishbone master
  always_comb begin
    wb_m2s.cyc = (state == st_bus);
    wb_m2s.stb = (state == st_bus);
    wb_m2s.we  = req_q.we;
    wb_m2s.adr = req_q.addr;
    wb_m2s.dat = req_q.data;
  end

endmodule

// File: rtl/req_gen.sv
/*
 * Paced request generator. Waits a holdoff after reset, then issues
 * write, read-back and fresh-read requests spaced by a ready-cycle distance.
 */
`timescale 1ns/10ps

module req_gen #(
  parameter int holdoff  = 80,  // Cycles before the first request, up to 255
  parameter int distance = 0    // Idle ready cycles between requests, 0 to 15
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [15:0]           seed,
  input  logic                  req_ready,
  output logic                  req_valid,
  output cache_pkg::cache_req_t req
);

  logic [7:0]  holdoff_cnt;
  logic [3:0]  gap_cnt;
  logic [1:0]  step;      // 0 waits out the holdoff
  logic [15:0] rng;
  logic [15:0] rng_next;
  logic        holdoff_counting;
  logic        accept;

  function automatic logic [15:0] xorshift16(input logic [15:0] x);
    logic [15:0] y;
    y = x ^ (x << 7);
    y = y ^ (y >> 9);
    y = y ^ (y << 8);
    return y;
  endfunction

  assign holdoff_counting = (holdoff_cnt != 8'd0);
  assign accept           = req_valid & req_ready;
  assign rng_next         = xorshift16(rng);

  // ==================================================
  // Pacing
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      holdoff_cnt <= 8'(holdoff);
      gap_cnt     <= 4'd0;
    end else begin
      if (holdoff_counting) begin
        holdoff_cnt <= holdoff_cnt - 8'd1;
      end
      if (accept) begin
        gap_cnt <= 4'(distance);  // Restart spacing
      end else if (req_ready && gap_cnt != 4'd0) begin
        gap_cnt <= gap_cnt - 4'd1;
      end
    end
  end

  assign req_valid = (step != 2'd0) && (gap_cnt == 4'd0);

  // ==================================================
  // Step sequence and address source
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      step <= 2'd0;
      rng  <= (seed == 16'd0) ? cache_pkg::xorshift_seed_default : seed;
    end else begin
      case (step)
        2'd0: begin
          if (!holdoff_counting) begin
            step <= 2'd1;
          end
        end
        2'd1: begin
          if (accept) begin
            step <= 2'd2;
            rng  <= rng_next;  // Address A now in rng
          end
        end
        2'd2: begin
          if (accept) begin
            step <= 2'd3;
          end
        end
        default: begin
          if (accept) begin
            step <= 2'd1;
            rng  <= rng_next;
          end
        end
      endcase
    end
  end

  always_comb begin
    req = '0;
    case (step)
      2'd1: begin
        req.we   = 1'b1;
        req.addr = rng_next[cache_pkg::addr_w-1:0];
        req.data = {rng_next[14:0], rng_next[15]};  // Rotate left by one
      end
      2'd2: req.addr = rng[cache_pkg::addr_w-1:0];  // Read back A
      2'd3: req.addr = rng_next[cache_pkg::addr_w-1:0];
      default: req = '0;
    endcase
  end

endmodule

// File: rtl/cache_pkg.sv
/*
 * Shared widths, request and response records and Wishbone bundles for the
 * cache test subsystem. Modules refer to these by scoped name.
 */
package cache_pkg;

  // ==================================================
  // Widths and constants
  // ==================================================
  localparam int addr_w = 10;  // Word address
  localparam int data_w = 16;

  localparam logic [15:0] xorshift_seed_default = 16'hace1;  // Replaces a zero seed

  // ==================================================
  // Request and response records
  // ==================================================
  typedef struct packed {
    logic              we;    // Store when set
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;  // Zero for reads
  } cache_req_t;

  typedef struct packed {
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;  // Read value or stored value
    logic              hit;
  } cache_rsp_t;

  // Wishbone classic between cache and memory
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic              ack;
    logic [data_w-1:0] dat;
  } wb_s2m_t;

endpackage
